// ==== Bender.yml ====
package:
  name: core_slice

sources:
  - include_dirs:
      - src
    files:
      - src/corePkg.sv
      - src/regBank.sv
      - src/instrDecoder.sv
      - src/aluExecute.sv
      - src/resultStage.sv
      - src/coreTop.sv

  - target: test
    include_dirs:
      - src
    files:
      - test/coreTb.sv

// ==== build.f ====
+incdir+src
src/corePkg.sv
src/regBank.sv
src/instrDecoder.sv
src/aluExecute.sv
src/resultStage.sv
src/coreTop.sv
test/coreTb.sv

// ==== src/aluExecute.sv ====
`include "core_macros.svh"

module aluExecute import corePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    exValid,
    input  logic [4:0]              exDest,
    input  aluOpT                   exOp,
    input  logic [`CORE_DATA_W-1:0] exOpA,
    input  logic [`CORE_DATA_W-1:0] exOpB,
    output logic                    fwdExValid,
    output logic [4:0]              fwdExDest,
    output logic [`CORE_DATA_W-1:0] fwdExData,
    output logic                    wbValid,
    output logic [4:0]              wbDest,
    output logic [`CORE_DATA_W-1:0] wbData
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                    validQ;
    logic [4:0]              destQ;
    aluOpT                   opQ;
    logic [`CORE_DATA_W-1:0] opAQ;
    logic [`CORE_DATA_W-1:0] opBQ;
    logic [`CORE_DATA_W-1:0] aluResult;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        destQ <= exDest;
        opQ   <= exOp;
        opAQ  <= exOpA;
        opBQ  <= exOpB;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (opQ)
            ALU_ADD: aluResult = opAQ + opBQ; // Wraps modulo 2 to the 32
            ALU_SUB: aluResult = opAQ - opBQ;
            ALU_AND: aluResult = opAQ & opBQ;
            ALU_OR:  aluResult = opAQ | opBQ;
            ALU_XOR: aluResult = opAQ ^ opBQ;
            ALU_SLT: begin
                // Signed compare gives 1 or 0
                aluResult = ($signed(opAQ) < $signed(opBQ)) ? `CORE_DATA_W'(1) : '0;
            end
            ALU_LUI: aluResult = opBQ; // Immediate was already shifted in decode
            default: aluResult = '0;
        endcase
    end

    // Seen by decode in the same cycle for back-to-back dependencies
    assign fwdExValid = validQ;
    assign fwdExDest  = destQ;
    assign fwdExData  = aluResult;

    // Captured by the result stage at the next edge
    assign wbValid = validQ;
    assign wbDest  = destQ;
    assign wbData  = aluResult;

endmodule

// ==== src/corePkg.sv ====
package corePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [5:0] {
        OP_REG  = 6'h00, // Register form, operation picked by the function field
        OP_ADDI = 6'h08,
        OP_LUI  = 6'h0f
    } opcodeT;

    typedef enum logic [10:0] {
        FN_ADD = 11'h020,
        FN_SUB = 11'h022,
        FN_AND = 11'h024,
        FN_OR  = 11'h025,
        FN_XOR = 11'h026,
        FN_SLT = 11'h02a
    } functT;

    // Register form: rd = rs op rt
    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        functT       funct;
    } regFormT;

    // Immediate form: rd = rs op imm
    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [15:0] imm;
    } immFormT;

    // The opcode sits in the same bits in both views
    typedef union packed {
        regFormT rForm;
        immFormT iForm;
    } instrT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal ALU operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_LUI = 4'd6, // Result is operand B as is
        ALU_NOP = 4'd15
    } aluOpT;

endpackage

// ==== src/coreTop.sv ====
`include "core_macros.svh"

module coreTop import corePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instrValid,
    input  instrT                   instr,
    output logic                    instrCredit,
    output logic                    resValid,
    output logic [4:0]              resDest,
    output logic [`CORE_DATA_W-1:0] resData
);

    // Decode to execute
    logic                    exValid;
    logic [4:0]              exDest;
    aluOpT                   exOp;
    logic [`CORE_DATA_W-1:0] exOpA;
    logic [`CORE_DATA_W-1:0] exOpB;

    // Register bank read and write
    logic [4:0]                     rs;
    logic [4:0]                     rt;
    logic signed [`CORE_DATA_W-1:0] rdData1;
    logic signed [`CORE_DATA_W-1:0] rdData2;
    logic                           wrReg;
    logic [4:0]                     destReg;
    logic [`CORE_DATA_W-1:0]        wrData;

    // Execute outputs, to forwarding and to the result stage
    logic                    fwdExValid;
    logic [4:0]              fwdExDest;
    logic [`CORE_DATA_W-1:0] fwdExData;
    logic                    wbValid;
    logic [4:0]              wbDest;
    logic [`CORE_DATA_W-1:0] wbData;

    instrDecoder decoder_i (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrCredit (instrCredit),
        .rs          (rs),
        .rt          (rt),
        .rdData1     (rdData1),
        .rdData2     (rdData2),
        .exValid     (exValid),
        .exDest      (exDest),
        .exOp        (exOp),
        .exOpA       (exOpA),
        .exOpB       (exOpB),
        .fwdExValid  (fwdExValid),
        .fwdExDest   (fwdExDest),
        .fwdExData   (fwdExData),
        .wbValid     (wrReg), // Result stage forwarding covers the bank write cycle
        .wbDest      (destReg),
        .wbData      (wrData)
    );

    aluExecute execute_i (
        .clk        (clk),
        .rst        (rst),
        .exValid    (exValid),
        .exDest     (exDest),
        .exOp       (exOp),
        .exOpA      (exOpA),
        .exOpB      (exOpB),
        .fwdExValid (fwdExValid),
        .fwdExDest  (fwdExDest),
        .fwdExData  (fwdExData),
        .wbValid    (wbValid),
        .wbDest     (wbDest),
        .wbData     (wbData)
    );

    resultStage result_i (
        .clk      (clk),
        .rst      (rst),
        .wbValid  (wbValid),
        .wbDest   (wbDest),
        .wbData   (wbData),
        .wrReg    (wrReg),
        .destReg  (destReg),
        .wrData   (wrData),
        .resValid (resValid),
        .resDest  (resDest),
        .resData  (resData)
    );

    regBank bank_i (
        .clk     (clk),
        .rst     (rst),
        .wrReg   (wrReg),
        .rs      (rs),
        .rt      (rt),
        .destReg (destReg),
        .wrData  (wrData),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

endmodule

// ==== src/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath and register file geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Width of every register and of the ALU
`define CORE_DATA_W 32

// R0 to R15 plus the return register
`define CORE_REG_N 17

`define CORE_RET_REG 16 // Return register index

// Value of the return register after reset
`define CORE_RET_RESET 1023

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input flow control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Input buffer depth, and also the credits the sender holds after reset.
// Any depth of 2 or more works
`define CORE_CREDITS 4

`endif

// ==== src/instrDecoder.sv ====
`include "core_macros.svh"

module instrDecoder import corePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instrValid,
    input  instrT                   instr,
    output logic                    instrCredit,
    output logic [4:0]              rs,
    output logic [4:0]              rt,
    input  logic [`CORE_DATA_W-1:0] rdData1,
    input  logic [`CORE_DATA_W-1:0] rdData2,
    output logic                    exValid,
    output logic [4:0]              exDest,
    output aluOpT                   exOp,
    output logic [`CORE_DATA_W-1:0] exOpA,
    output logic [`CORE_DATA_W-1:0] exOpB,
    input  logic                    fwdExValid,
    input  logic [4:0]              fwdExDest,
    input  logic [`CORE_DATA_W-1:0] fwdExData,
    input  logic                    wbValid,
    input  logic [4:0]              wbDest,
    input  logic [`CORE_DATA_W-1:0] wbData
);

    localparam int PtrW = $clog2(`CORE_CREDITS);
    localparam int CntW = $clog2(`CORE_CREDITS + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    instrT           fifoMem [0:`CORE_CREDITS-1];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] fill;
    logic            pop;
    instrT           head;

    assign pop  = (fill != '0); // Head is issued every cycle it exists
    assign head = fifoMem[rdPtr];

    always_ff @(posedge clk) begin
        if (instrValid) begin
            fifoMem[wrPtr] <= instr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            fill        <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (instrValid) begin
                wrPtr <= (wrPtr == PtrW'(`CORE_CREDITS - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(`CORE_CREDITS - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({instrValid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            instrCredit <= pop; // One credit back per slot freed
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode and operand read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                    useImm;
    logic [`CORE_DATA_W-1:0] immVal;
    logic [`CORE_DATA_W-1:0] operandS;
    logic [`CORE_DATA_W-1:0] operandT;

    // Newest producer wins, then the bank
    function automatic logic [`CORE_DATA_W-1:0] pickOperand(
        input logic [4:0]              src,
        input logic [`CORE_DATA_W-1:0] bankData,
        input logic                    exV,
        input logic [4:0]              exD,
        input logic [`CORE_DATA_W-1:0] exData,
        input logic                    wbV,
        input logic [4:0]              wbD,
        input logic [`CORE_DATA_W-1:0] wbRes
    );
        logic live;
        live = (src != 5'd0) && (src < `CORE_REG_N);
        if (live && exV && (exD == src)) begin
            return exData;
        end else if (live && wbV && (wbD == src)) begin
            return wbRes;
        end
        return bankData;
    endfunction

    // The rt field overlaps the immediate, reading it there is harmless
    assign rs = head.rForm.rs;
    assign rt = head.rForm.rt;

    assign operandS = pickOperand(rs, rdData1, fwdExValid, fwdExDest, fwdExData,
                                  wbValid, wbDest, wbData);
    assign operandT = pickOperand(rt, rdData2, fwdExValid, fwdExDest, fwdExData,
                                  wbValid, wbDest, wbData);

    always_comb begin
        exOp   = ALU_NOP;
        exDest = 5'd0;
        useImm = 1'b0;
        immVal = '0;
        case (head.rForm.opcode)
            OP_REG: begin
                exDest = head.rForm.rd;
                case (head.rForm.funct)
                    FN_ADD:  exOp = ALU_ADD;
                    FN_SUB:  exOp = ALU_SUB;
                    FN_AND:  exOp = ALU_AND;
                    FN_OR:   exOp = ALU_OR;
                    FN_XOR:  exOp = ALU_XOR;
                    FN_SLT:  exOp = ALU_SLT;
                    default: exDest = 5'd0; // Unknown function retires as a NOP
                endcase
            end
            OP_ADDI: begin
                exOp   = ALU_ADD;
                exDest = head.iForm.rd;
                useImm = 1'b1;
                immVal = {{(`CORE_DATA_W - 16){head.iForm.imm[15]}}, head.iForm.imm};
            end
            OP_LUI: begin
                exOp   = ALU_LUI;
                exDest = head.iForm.rd;
                useImm = 1'b1;
                immVal = {head.iForm.imm, {(`CORE_DATA_W - 16){1'b0}}};
            end
            default: ;
        endcase
    end

    assign exValid = pop;
    assign exOpA   = operandS;
    assign exOpB   = useImm ? immVal : operandT;

endmodule

// ==== src/regBank.sv ====
`include "core_macros.svh"

module regBank (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wrReg,
    input  logic [4:0]                     rs,
    input  logic [4:0]                     rt,
    input  logic [4:0]                     destReg,
    input  logic [`CORE_DATA_W-1:0]        wrData,
    output logic signed [`CORE_DATA_W-1:0] rdData1,
    output logic signed [`CORE_DATA_W-1:0] rdData2
);

    // R0 has no storage since it always reads zero
    logic signed [`CORE_DATA_W-1:0] regs [1:`CORE_REG_N-1];

    logic rsValid;
    logic rtValid;
    logic wrValid;

    assign rsValid = (rs != 5'd0) && (rs < `CORE_REG_N);
    assign rtValid = (rt != 5'd0) && (rt < `CORE_REG_N);
    assign wrValid = wrReg && (destReg != 5'd0) && (destReg < `CORE_REG_N);

    // Unimplemented indices read as zero
    assign rdData1 = rsValid ? regs[rs] : '0;
    assign rdData2 = rtValid ? regs[rt] : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `CORE_REG_N; i++) begin
                if (i == `CORE_RET_REG) begin
                    regs[i] <= `CORE_DATA_W'(`CORE_RET_RESET);
                end else begin
                    regs[i] <= '0;
                end
            end
        end else if (wrValid) begin
            regs[destReg] <= wrData; // Same-cycle readers get this value by forwarding
        end
    end

endmodule

// ==== src/resultStage.sv ====
`include "core_macros.svh"

module resultStage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wbValid,
    input  logic [4:0]              wbDest,
    input  logic [`CORE_DATA_W-1:0] wbData,
    output logic                    wrReg,
    output logic [4:0]              destReg,
    output logic [`CORE_DATA_W-1:0] wrData,
    output logic                    resValid,
    output logic [4:0]              resDest,
    output logic [`CORE_DATA_W-1:0] resData
);

    logic                    validQ;
    logic [4:0]              destQ;
    logic [`CORE_DATA_W-1:0] dataQ;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= wbValid;
        end
    end

    // R0 results are reported as zero like a read of R0 would give
    always_ff @(posedge clk) begin
        destQ <= wbDest;
        dataQ <= (wbDest == 5'd0) ? '0 : wbData;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bank write and result port share one register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign wrReg   = validQ && (destQ != 5'd0); // R0 is never written
    assign destReg = destQ;
    assign wrData  = dataQ;

    assign resValid = validQ; // Every retired instruction is reported
    assign resDest  = destQ;
    assign resData  = dataQ;

endmodule

// ==== test/coreTb.sv ====
`include "core_macros.svh"

module coreTb import corePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                    clk;
    logic                    rst;
    logic                    instrValid;
    instrT                   instr;
    logic                    instrCredit;
    logic                    resValid;
    logic [4:0]              resDest;
    logic [`CORE_DATA_W-1:0] resData;

    int credits = `CORE_CREDITS; // Sender side credit count
    int sentCnt = 0;
    int creditCnt = 0;
    int retiredCnt = 0;
    int resErrs = 0;
    int flowErrs = 0;
    int timeErrs = 0;

    logic [`CORE_DATA_W-1:0] modelRegs [0:31];
    logic [4:0]              expDest [$];
    logic [`CORE_DATA_W-1:0] expData [$];

    coreTop dut_i (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrCredit (instrCredit),
        .resValid    (resValid),
        .resDest     (resDest),
        .resData     (resData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [`CORE_DATA_W-1:0] readModel(input logic [4:0] idx);
        return (idx != 5'd0 && idx < `CORE_REG_N) ? modelRegs[idx] : '0;
    endfunction

    task automatic modelStep(input instrT w);
        logic [`CORE_DATA_W-1:0] a;
        logic [`CORE_DATA_W-1:0] b;
        logic [`CORE_DATA_W-1:0] res;
        logic [4:0]              dest;
        a    = readModel(w.rForm.rs);
        b    = readModel(w.rForm.rt);
        dest = w.rForm.rd;
        res  = '0;
        case (w.rForm.opcode)
            OP_REG: begin
                case (w.rForm.funct)
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: dest = 5'd0;
                endcase
            end
            OP_ADDI: res = a + {{16{w.iForm.imm[15]}}, w.iForm.imm};
            OP_LUI:  res = {w.iForm.imm, 16'h0000};
            default: dest = 5'd0;
        endcase
        if (dest == 5'd0) res = '0; // R0 results report as zero
        if (dest != 5'd0 && dest < `CORE_REG_N) modelRegs[dest] = res;
        expDest.push_back(dest);
        expData.push_back(res);
    endtask

    function automatic instrT regInstr(input functT f, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
        instrT w;
        w.rForm.opcode = OP_REG;
        w.rForm.rd     = rd;
        w.rForm.rs     = rs;
        w.rForm.rt     = rt;
        w.rForm.funct  = f;
        return w;
    endfunction

    function automatic instrT immInstr(input opcodeT op, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [15:0] imm);
        instrT w;
        w.iForm.opcode = op;
        w.iForm.rd     = rd;
        w.iForm.rs     = rs;
        w.iForm.imm    = imm;
        return w;
    endfunction

    function automatic logic [4:0] randReg();
        // Mostly real registers, sometimes the unimplemented indices
        if ($urandom_range(0, 7) == 0) return 5'($urandom_range(17, 31));
        return 5'($urandom_range(0, 16));
    endfunction

    function automatic functT pickFunct(input int k);
        case (k)
            0:       return FN_ADD;
            1:       return FN_SUB;
            2:       return FN_AND;
            3:       return FN_OR;
            4:       return FN_XOR;
            default: return FN_SLT;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sender tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // After a timeout the remaining sends and drains are skipped
    task automatic reportTimeout(input string what);
        $display("Timeout: gave up waiting for %s", what);
        timeErrs++;
    endtask

    task automatic sendInstr(input instrT w);
        int t;
        t = 0;
        if (timeErrs == 0) begin
            while (credits == 0 && t < 50) begin
                instrValid = 1'b0;
                @(posedge clk);
                #5;
                t++;
            end
            if (credits == 0) begin
                reportTimeout("an input credit");
            end else begin
                instr      = w;
                instrValid = 1'b1;
                credits--;
                sentCnt++;
                modelStep(w);
                @(posedge clk);
                #5;
                instrValid = 1'b0;
            end
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    // Returns once every result is in and every credit is back
    task automatic drain();
        int t;
        t = 0;
        if (timeErrs == 0) begin
            while ((expData.size() != 0 || credits != `CORE_CREDITS) && t < 100) begin
                @(posedge clk);
                #5;
                t++;
            end
            if (expData.size() != 0 || credits != `CORE_CREDITS) begin
                reportTimeout("the pipeline to drain");
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin : monitor
        logic [4:0]              eDest;
        logic [`CORE_DATA_W-1:0] eData;
        if (!rst && instrCredit) begin
            credits++;
            creditCnt++;
            assert (creditCnt <= sentCnt) else begin
                flowErrs++;
                $display("More credits returned than instructions sent");
            end
        end
        assert (credits >= 0 && credits <= `CORE_CREDITS) else begin
            flowErrs++;
            $display("Error: credits out of range, got %h", credits);
        end
        if (!rst && resValid) begin
            if (expData.size() == 0) begin
                resErrs++;
                $display("A result was reported with no instruction outstanding");
            end else begin
                eDest = expDest.pop_front();
                eData = expData.pop_front();
                retiredCnt++;
                assert (resDest == eDest) else begin
                    resErrs++;
                    $display("Error: resDest got %h, expected %h", resDest, eDest);
                end
                assert (resData == eData) else begin
                    resErrs++;
                    $display("Error: resData got %h, expected %h", resData, eData);
                end
            end
        end
    end

    quietAfterReset: assert property (@(posedge clk) disable iff (rst)
        (sentCnt == 0) |-> (!instrCredit && !resValid))
    else begin
        flowErrs++;
        $display("Credit or result pulse seen before any instruction was sent");
    end

    // Accepted into an empty pipeline, the result shows three edges later
    idleLatency: assert property (@(posedge clk) disable iff (rst)
        (instrValid && (sentCnt - retiredCnt == 1)) |-> ##3 $rose(resValid))
    else begin
        resErrs++;
        $display("Result did not rise three cycles after an idle accept");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(24757));
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        modelRegs[`CORE_RET_REG] = `CORE_RET_RESET;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        idleCycles(4);
        sendInstr(regInstr(FN_ADD, 5'd1, 5'd16, 5'd0)); // Return register reset value
        drain();
        sendInstr(regInstr(FN_ADD, 5'd2, 5'd5, 5'd0));
        drain();
        for (int d = 1; d <= 3; d++) begin
            sendInstr(immInstr(OP_ADDI, 5'd3, 5'd3, 16'(d * 100 - 250)));
            for (int k = 1; k < d; k++) sendInstr(regInstr(FN_OR, 5'd9, 5'd16, 5'd0));
            sendInstr(regInstr(FN_SUB, 5'd5, 5'd16, 5'd3));
            sendInstr(regInstr(FN_XOR, 5'd6, 5'd5, 5'd3));
            drain();
        end
        sendInstr(immInstr(OP_ADDI, 5'd0, 5'd0, 16'd55));
        sendInstr(regInstr(FN_ADD, 5'd6, 5'd0, 5'd0));
        sendInstr(immInstr(OP_ADDI, 5'd20, 5'd16, 16'd77));
        sendInstr(regInstr(FN_ADD, 5'd7, 5'd20, 5'd20));
        sendInstr(immInstr(OP_LUI, 5'd31, 5'd0, 16'hbeef));
        sendInstr(regInstr(FN_OR, 5'd8, 5'd31, 5'd0));
        drain();
        repeat (300) begin
            if ($urandom_range(0, 7) < 6) begin
                sendInstr(regInstr(pickFunct($urandom_range(0, 5)), randReg(), randReg(),
                                   randReg()));
            end else begin
                sendInstr(immInstr(($urandom_range(0, 1) == 0) ? OP_ADDI : OP_LUI,
                                   randReg(), randReg(), 16'($urandom)));
            end
            if ($urandom_range(0, 7) == 0) idleCycles($urandom_range(0, 4));
        end
        drain();
        $display("Errors: %0d result, %0d flow control, %0d timeout", resErrs, flowErrs,
                 timeErrs);
        if (resErrs + flowErrs + timeErrs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
